/* verilog/core_pkg.sv */
package core_pkg;

    // Core dimensions
    localparam int num_warps_max = 4;
    localparam int num_lanes = 4;
    localparam int data_w = 8;
    localparam int num_regs = 8;
    localparam int pc_w = 8;

    typedef logic [data_w-1:0] data_t;
    typedef logic [pc_w-1:0] pc_t;
    typedef logic [$clog2(num_regs)-1:0] reg_addr_t;
    typedef logic [$clog2(num_warps_max)-1:0] warp_id_t;
    typedef logic [$clog2(num_warps_max+1)-1:0] warp_count_t;
    typedef logic [$clog2(num_lanes)-1:0] lane_id_t;

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_XOR  = 4'd4,
        OP_LDI  = 4'd5,
        OP_TID  = 4'd6,
        OP_STR  = 4'd7,
        OP_HALT = 4'd15
    } opcode_t;

    // Register form, used by ALU ops, TID and STR
    typedef struct packed {
        opcode_t opcode;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic [2:0] spare;
    } r_fields_t;

    // Immediate form, used by LDI
    typedef struct packed {
        opcode_t opcode;
        reg_addr_t rd;
        logic spare;
        data_t imm;
    } i_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
    } instr_t;

    typedef struct packed {
        opcode_t op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        data_t imm;
        logic writes_reg;
        logic is_store;
        logic is_halt;
    } decoded_t;

    typedef enum logic [2:0] {
        WARP_IDLE,
        WARP_FETCH,
        WARP_DECODE,
        WARP_EXECUTE,
        WARP_WAIT,
        WARP_UPDATE,
        WARP_DONE
    } warp_state_t;

endpackage

/* verilog/warp_fetcher.sv */
`timescale 1ns/100ps

module warp_fetcher (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::warp_state_t state,
    input  core_pkg::pc_t         pc,
    output logic                  read_valid,
    output core_pkg::pc_t         read_address,
    input  logic                  read_ready,
    input  core_pkg::instr_t      read_data,
    output logic                  fetch_done,
    output core_pkg::instr_t      instr
);
    import core_pkg::*;

    // One cycle pulse on the accepted read
    assign fetch_done = read_valid && read_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            read_valid <= 1'b0;
        end else if (read_valid) begin
            if (read_ready) begin
                read_valid <= 1'b0;
            end
        end else if (state == WARP_FETCH) begin
            read_valid <= 1'b1;
        end
    end

    // Address is captured on entry to FETCH and the word on the handshake
    always_ff @(posedge clk) begin
        if (!read_valid && state == WARP_FETCH) begin
            read_address <= pc;
        end
        if (read_valid && read_ready) begin
            instr <= read_data;
        end
    end

    // Warp stays in FETCH on the same PC for as long as the request waits
    address_held: assert property (
        @(posedge clk) disable iff (reset)
        read_valid |-> state == WARP_FETCH && read_address == pc
    );

endmodule

/* verilog/warp_decoder.sv */
`timescale 1ns/100ps

module warp_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::warp_state_t state,
    input  core_pkg::instr_t      instr,
    output core_pkg::decoded_t    decoded
);
    import core_pkg::*;

    decoded_t next_decoded;

    always_comb begin
        next_decoded = '0;
        next_decoded.op = OP_NOP;
        case (instr.r_fields.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                next_decoded.op = instr.r_fields.opcode;
                next_decoded.rd = instr.r_fields.rd;
                next_decoded.rs1 = instr.r_fields.rs1;
                next_decoded.rs2 = instr.r_fields.rs2;
                next_decoded.writes_reg = 1'b1;
            end
            OP_LDI: begin
                // Immediate view of the same word
                next_decoded.op = OP_LDI;
                next_decoded.rd = instr.i_fields.rd;
                next_decoded.imm = instr.i_fields.imm;
                next_decoded.writes_reg = 1'b1;
            end
            OP_TID: begin
                next_decoded.op = OP_TID;
                next_decoded.rd = instr.r_fields.rd;
                next_decoded.writes_reg = 1'b1;
            end
            OP_STR: begin
                // rs1 is the address, rs2 the data
                next_decoded.op = OP_STR;
                next_decoded.rs1 = instr.r_fields.rs1;
                next_decoded.rs2 = instr.r_fields.rs2;
                next_decoded.is_store = 1'b1;
            end
            OP_HALT: begin
                next_decoded.op = OP_HALT;
                next_decoded.is_halt = 1'b1;
            end
            default: begin
                next_decoded.op = OP_NOP;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded <= '0;
        end else if (state == WARP_DECODE) begin
            decoded <= next_decoded;
        end
    end

endmodule

/* verilog/warp_scheduler.sv */
`timescale 1ns/100ps

module warp_scheduler (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    input  core_pkg::warp_count_t                num_warps,
    input  core_pkg::pc_t                        base_pc,
    input  logic [core_pkg::num_warps_max-1:0]   fetch_done,
    input  logic                                 halt,
    input  core_pkg::decoded_t                   current_decoded,
    input  logic [core_pkg::num_lanes-1:0]       store_busy,
    output core_pkg::warp_state_t                warp_state [core_pkg::num_warps_max],
    output core_pkg::pc_t                        pc [core_pkg::num_warps_max],
    output core_pkg::warp_id_t                   current_warp,
    output logic                                 reg_write,
    output logic                                 issue_store,
    output logic                                 done
);
    import core_pkg::*;

    logic started;
    logic all_done;
    logic found;
    warp_id_t next_warp;
    warp_state_t current_state;

    assign current_state = warp_state[current_warp];

    // Datapath strobes fire in the single EXECUTE cycle
    assign reg_write = (current_state == WARP_EXECUTE) && current_decoded.writes_reg;
    assign issue_store = (current_state == WARP_EXECUTE) && current_decoded.is_store;

    // Round-robin search starting after the current warp
    always_comb begin
        warp_id_t cand;
        found = 1'b0;
        next_warp = current_warp;
        for (int k = 1; k <= num_warps_max; k++) begin
            cand = current_warp + warp_id_t'(k);
            if (!found && warp_state[cand] inside
                    {WARP_DECODE, WARP_EXECUTE, WARP_WAIT, WARP_UPDATE}) begin
                found = 1'b1;
                next_warp = cand;
            end
        end
    end

    // Inactive warps stay idle, so idle or done everywhere means finished
    always_comb begin
        all_done = started;
        for (int i = 0; i < num_warps_max; i++) begin
            if (!(warp_state[i] inside {WARP_IDLE, WARP_DONE})) begin
                all_done = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
            done <= 1'b0;
            current_warp <= '0;
            for (int i = 0; i < num_warps_max; i++) begin
                warp_state[i] <= WARP_IDLE;
                pc[i] <= '0;
            end
        end else if (!started) begin
            if (start) begin
                started <= 1'b1;
                current_warp <= '0;
                for (int i = 0; i < num_warps_max; i++) begin
                    if (i < num_warps) begin
                        warp_state[i] <= WARP_FETCH;
                        pc[i] <= base_pc;
                    end
                end
            end
        end else begin
            if (all_done) begin
                done <= 1'b1;
            end

            // Fetches complete independently of the selected warp
            for (int i = 0; i < num_warps_max; i++) begin
                if (warp_state[i] == WARP_FETCH && fetch_done[i]) begin
                    warp_state[i] <= WARP_DECODE;
                end
            end

            if ((current_state == WARP_UPDATE || current_state == WARP_DONE) && found) begin
                current_warp <= next_warp;
            end

            case (current_state)
                WARP_DECODE: warp_state[current_warp] <= WARP_EXECUTE;
                WARP_EXECUTE: warp_state[current_warp] <= WARP_WAIT;
                WARP_WAIT: begin
                    if (!(|store_busy)) begin
                        warp_state[current_warp] <= WARP_UPDATE;
                    end
                end
                WARP_UPDATE: begin
                    if (halt) begin
                        warp_state[current_warp] <= WARP_DONE;
                    end else begin
                        pc[current_warp] <= pc[current_warp] + pc_t'(1);
                        warp_state[current_warp] <= WARP_FETCH;
                    end
                end
                default: ;
            endcase
        end
    end

    // The warp holding the datapath has no fetch in flight
    no_fetch_while_selected: assert property (
        @(posedge clk) disable iff (reset)
        current_state inside {WARP_DECODE, WARP_EXECUTE, WARP_WAIT}
            |-> !fetch_done[current_warp]
    );

endmodule

/* verilog/lane_alu.sv */
`timescale 1ns/100ps

module lane_alu (
    input  core_pkg::decoded_t    decoded,
    input  core_pkg::data_t       op_a,
    input  core_pkg::data_t       op_b,
    input  core_pkg::data_t       block_id,
    input  core_pkg::warp_count_t num_warps,
    input  core_pkg::warp_id_t    warp,
    input  core_pkg::lane_id_t    lane,
    output core_pkg::data_t       result
);
    import core_pkg::*;

    data_t warp_base;
    data_t thread_id;

    // Global thread id, wraps at the data width
    assign warp_base = block_id * data_t'(num_warps) + data_t'(warp);
    assign thread_id = warp_base * data_t'(num_lanes) + data_t'(lane);

    always_comb begin
        case (decoded.op)
            OP_ADD: result = op_a + op_b;
            OP_SUB: result = op_a - op_b;
            OP_AND: result = op_a & op_b;
            OP_XOR: result = op_a ^ op_b;
            OP_LDI: result = decoded.imm;
            OP_TID: result = thread_id;
            default: result = '0;
        endcase
    end

endmodule

/* verilog/lane_store_unit.sv */
`timescale 1ns/100ps

module lane_store_unit (
    input  logic            clk,
    input  logic            reset,
    input  logic            issue,
    input  core_pkg::data_t address,
    input  core_pkg::data_t data,
    output logic            write_valid,
    output core_pkg::data_t write_address,
    output core_pkg::data_t write_data,
    input  logic            write_ready,
    output logic            busy
);
    import core_pkg::*;

    // Busy for as long as a request is outstanding
    assign busy = write_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            write_valid <= 1'b0;
        end else if (issue) begin
            write_valid <= 1'b1;
        end else if (write_valid && write_ready) begin
            write_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            write_address <= address;
            write_data <= data;
        end
    end

    // Scheduler holds the warp in WAIT until every lane has drained
    no_issue_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        issue |-> !busy
    );

endmodule

/* verilog/vector_reg_file.sv */
`timescale 1ns/100ps

module vector_reg_file (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::warp_id_t  warp,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  core_pkg::reg_addr_t rd,
    input  logic                write,
    input  core_pkg::data_t     write_data [core_pkg::num_lanes],
    output core_pkg::data_t     read_a [core_pkg::num_lanes],
    output core_pkg::data_t     read_b [core_pkg::num_lanes]
);
    import core_pkg::*;

    // Indexed by warp, then lane, then register
    data_t regs [num_warps_max][num_lanes][num_regs];

    always_comb begin
        for (int l = 0; l < num_lanes; l++) begin
            read_a[l] = regs[warp][l][rs1];
            read_b[l] = regs[warp][l][rs2];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < num_warps_max; w++) begin
                for (int l = 0; l < num_lanes; l++) begin
                    for (int r = 0; r < num_regs; r++) begin
                        regs[w][l][r] <= '0;
                    end
                end
            end
        end else if (write) begin
            // All lanes of the warp write the same rd
            for (int l = 0; l < num_lanes; l++) begin
                regs[warp][l][rd] <= write_data[l];
            end
        end
    end

endmodule

/* verilog/compute_core.sv */
`timescale 1ns/100ps

module compute_core (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               start,
    output logic                               done,
    input  core_pkg::data_t                    block_id,
    input  core_pkg::warp_count_t              num_warps,
    input  core_pkg::pc_t                      base_pc,
    output logic [core_pkg::num_warps_max-1:0] imem_read_valid,
    output core_pkg::pc_t                      imem_read_address [core_pkg::num_warps_max],
    input  logic [core_pkg::num_warps_max-1:0] imem_read_ready,
    input  core_pkg::instr_t                   imem_read_data [core_pkg::num_warps_max],
    output logic [core_pkg::num_lanes-1:0]     dmem_write_valid,
    output core_pkg::data_t                    dmem_write_address [core_pkg::num_lanes],
    output core_pkg::data_t                    dmem_write_data [core_pkg::num_lanes],
    input  logic [core_pkg::num_lanes-1:0]     dmem_write_ready
);
    import core_pkg::*;

    warp_state_t warp_state [num_warps_max];
    pc_t pc [num_warps_max];
    logic [num_warps_max-1:0] fetch_done;
    instr_t fetched [num_warps_max];
    decoded_t decoded [num_warps_max];

    warp_id_t current_warp;
    decoded_t current_decoded;
    logic reg_write;
    logic issue_store;
    logic [num_lanes-1:0] store_busy;
    data_t read_a [num_lanes];
    data_t read_b [num_lanes];
    data_t alu_result [num_lanes];

    // Shared datapath follows the selected warp
    assign current_decoded = decoded[current_warp];

    warp_scheduler scheduler (
        .clk(clk),
        .reset(reset),
        .start(start),
        .num_warps(num_warps),
        .base_pc(base_pc),
        .fetch_done(fetch_done),
        .halt(current_decoded.is_halt),
        .current_decoded(current_decoded),
        .store_busy(store_busy),
        .warp_state(warp_state),
        .pc(pc),
        .current_warp(current_warp),
        .reg_write(reg_write),
        .issue_store(issue_store),
        .done(done)
    );

    vector_reg_file reg_file (
        .clk(clk),
        .reset(reset),
        .warp(current_warp),
        .rs1(current_decoded.rs1),
        .rs2(current_decoded.rs2),
        .rd(current_decoded.rd),
        .write(reg_write),
        .write_data(alu_result),
        .read_a(read_a),
        .read_b(read_b)
    );

    for (genvar w = 0; w < num_warps_max; w++) begin : g_warp
        warp_fetcher fetcher (
            .clk(clk),
            .reset(reset),
            .state(warp_state[w]),
            .pc(pc[w]),
            .read_valid(imem_read_valid[w]),
            .read_address(imem_read_address[w]),
            .read_ready(imem_read_ready[w]),
            .read_data(imem_read_data[w]),
            .fetch_done(fetch_done[w]),
            .instr(fetched[w])
        );

        warp_decoder decoder (
            .clk(clk),
            .reset(reset),
            .state(warp_state[w]),
            .instr(fetched[w]),
            .decoded(decoded[w])
        );
    end

    for (genvar l = 0; l < num_lanes; l++) begin : g_lane
        lane_alu alu (
            .decoded(current_decoded),
            .op_a(read_a[l]),
            .op_b(read_b[l]),
            .block_id(block_id),
            .num_warps(num_warps),
            .warp(current_warp),
            .lane(lane_id_t'(l)),
            .result(alu_result[l])
        );

        lane_store_unit store_unit (
            .clk(clk),
            .reset(reset),
            .issue(issue_store),
            .address(read_a[l]),
            .data(read_b[l]),
            .write_valid(dmem_write_valid[l]),
            .write_address(dmem_write_address[l]),
            .write_data(dmem_write_data[l]),
            .write_ready(dmem_write_ready[l]),
            .busy(store_busy[l])
        );
    end

endmodule

/* bench/compute_core_model.svh */
// Expected store, one entry per lane and STR
typedef struct packed {
    lane_id_t lane;
    data_t address;
    data_t data;
} write_t;

instr_t program_words [$];
write_t expected [$];

// Random program of 6 to 12 instructions closed by HALT
task automatic gen_program(input int mode);
    instr_t words [12];
    instr_t halt_word;
    logic [31:0] bits;
    opcode_t op;
    int len;
    len = 6 + {$random(seed)} % 7;
    for (int i = 0; i < len; i++) begin
        bits = $random(seed);
        case ({$random(seed)} % 7)
            0: op = OP_LDI;
            1: op = OP_ADD;
            2: op = OP_SUB;
            3: op = OP_AND;
            4: op = OP_XOR;
            5: op = OP_TID;
            default: op = OP_STR;
        endcase
        if (mode == 0 && op == OP_TID) begin
            op = OP_LDI;
        end
        if (mode == 1 && op == OP_AND) begin
            op = OP_TID;
        end
        if (i == 0) begin
            op = (mode == 1) ? OP_TID : OP_LDI;
        end
        if (i == len - 1) begin
            op = OP_STR;
        end
        // Spare bits stay random
        words[i] = bits[15:0];
        words[i].r_fields.opcode = op;
    end
    // Thread id mode ends by storing each thread id at its own address
    if (mode == 1) begin
        words[len-2].r_fields.opcode = OP_TID;
        words[len-1].r_fields.rs1 = words[len-2].r_fields.rd;
        words[len-1].r_fields.rs2 = words[len-2].r_fields.rd;
    end
    program_words.delete();
    for (int i = 0; i < len; i++) begin
        program_words.push_back(words[i]);
    end
    bits = $random(seed);
    halt_word = bits[15:0];
    halt_word.r_fields.opcode = OP_HALT;
    program_words.push_back(halt_word);
endtask

// Background of NOPs tagged with their address, program at base
task automatic load_program(input pc_t base);
    for (int a = 0; a < 256; a++) begin
        prog_mem[a] = {8'h00, 8'(a)};
    end
    for (int i = 0; i < program_words.size(); i++) begin
        prog_mem[pc_t'(base + i)] = program_words[i];
    end
endtask

// Runs the program for every active warp and lane from cleared registers
task automatic build_expected(input int warps, input data_t block);
    data_t regs [num_regs];
    instr_t word;
    data_t a;
    data_t b;
    expected.delete();
    for (int w = 0; w < warps; w++) begin
        for (int l = 0; l < num_lanes; l++) begin
            for (int r = 0; r < num_regs; r++) begin
                regs[r] = '0;
            end
            for (int i = 0; i < program_words.size(); i++) begin
                word = program_words[i];
                a = regs[word.r_fields.rs1];
                b = regs[word.r_fields.rs2];
                case (word.r_fields.opcode)
                    OP_ADD: regs[word.r_fields.rd] = a + b;
                    OP_SUB: regs[word.r_fields.rd] = a - b;
                    OP_AND: regs[word.r_fields.rd] = a & b;
                    OP_XOR: regs[word.r_fields.rd] = a ^ b;
                    OP_LDI: regs[word.i_fields.rd] = word.i_fields.imm;
                    OP_TID: regs[word.r_fields.rd] =
                        data_t'((int'(block) * warps + w) * num_lanes + l);
                    OP_STR: expected.push_back('{lane_id_t'(l), a, b});
                    default: ;
                endcase
            end
        end
    end
endtask

/* bench/compute_core_tb.sv */
`timescale 1ns/100ps

module compute_core_tb;
    import core_pkg::*;

    localparam int num_tests = 9;
    localparam int timeout_cycles = 2000 * num_tests;

    integer seed = 32'h0d10adfd;
    int errors = 0;
    int cycles = 0;
    int tests_passed = 0;

    logic clk;
    logic reset = 1'b1;
    logic start = 1'b0;
    logic done;
    data_t block_id = '0;
    warp_count_t num_warps = 3'd1;
    pc_t base_pc = '0;
    logic [num_warps_max-1:0] imem_read_valid;
    pc_t imem_read_address [num_warps_max];
    logic [num_warps_max-1:0] imem_read_ready = '0;
    instr_t imem_read_data [num_warps_max] = '{default: '0};
    logic [num_lanes-1:0] dmem_write_valid;
    data_t dmem_write_address [num_lanes];
    data_t dmem_write_data [num_lanes];
    logic [num_lanes-1:0] dmem_write_ready = '0;

    // Instruction memory shared by all warps
    instr_t prog_mem [256];
    int imem_delay [num_warps_max];
    logic [num_warps_max-1:0] imem_pending = '0;
    pc_t imem_held [num_warps_max];
    int dmem_delay [num_lanes];
    logic [num_lanes-1:0] dmem_pending = '0;
    data_t dmem_held_address [num_lanes];
    data_t dmem_held_data [num_lanes];

    `include "compute_core_model.svh"

    compute_core compute_core_inst (
        .clk(clk),
        .reset(reset),
        .start(start),
        .done(done),
        .block_id(block_id),
        .num_warps(num_warps),
        .base_pc(base_pc),
        .imem_read_valid(imem_read_valid),
        .imem_read_address(imem_read_address),
        .imem_read_ready(imem_read_ready),
        .imem_read_data(imem_read_data),
        .dmem_write_valid(dmem_write_valid),
        .dmem_write_address(dmem_write_address),
        .dmem_write_data(dmem_write_data),
        .dmem_write_ready(dmem_write_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the core never finished", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic expect_value(input string name, input logic [31:0] actual,
                                input logic [31:0] want);
        assert (actual === want) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, want, actual);
        end
    endtask

    task automatic check_idle();
        expect_value("done", 32'(done), 0);
        expect_value("imem_read_valid", 32'(imem_read_valid), 0);
        expect_value("dmem_write_valid", 32'(dmem_write_valid), 0);
    endtask

    // Removes the accepted write from the expected multiset
    task automatic match_write(input lane_id_t lane, input data_t address, input data_t data);
        int hit;
        int near;
        hit = -1;
        near = -1;
        foreach (expected[i]) begin
            if (expected[i].lane == lane && expected[i].address == address) begin
                if (hit < 0 && expected[i].data == data) begin
                    hit = i;
                end
                if (near < 0) begin
                    near = i;
                end
            end
        end
        foreach (expected[i]) begin
            if (near < 0 && expected[i].lane == lane) begin
                near = i;
            end
        end
        assert (hit >= 0) else begin
            errors++;
            if (near >= 0) begin
                $display("CHECK FAILED at %0t: dmem_write_data[%0d] @%0h expected %0h@%0h got %0h",
                         $time, lane, address, expected[near].data, expected[near].address, data);
            end else begin
                $display("At %0t lane %0d wrote %0h to %0h but no write was left to expect",
                         $time, lane, data, address);
            end
        end
        if (hit >= 0) begin
            expected.delete(hit);
        end
    endtask

    // Instruction memory, each warp answered after 0 to 3 cycles
    always @(posedge clk) begin
        for (int w = 0; w < num_warps_max; w++) begin
            if (reset) begin
                imem_read_ready[w] <= 1'b0;
                imem_pending[w] <= 1'b0;
                imem_delay[w] <= {$random(seed)} % 4;
            end else begin
                if (imem_pending[w]) begin
                    assert (imem_read_valid[w]) else begin
                        errors++;
                        $display("At %0t imem_read_valid[%0d] dropped before ready", $time, w);
                    end
                    expect_value($sformatf("imem_read_address[%0d]", w),
                                 32'(imem_read_address[w]), 32'(imem_held[w]));
                end
                imem_pending[w] <= imem_read_valid[w] && !imem_read_ready[w];
                imem_held[w] <= imem_read_address[w];
                if (imem_read_valid[w] && imem_read_ready[w]) begin
                    imem_read_ready[w] <= 1'b0;
                    imem_delay[w] <= {$random(seed)} % 4;
                end else if (imem_read_valid[w]) begin
                    if (imem_delay[w] == 0) begin
                        imem_read_ready[w] <= 1'b1;
                        imem_read_data[w] <= prog_mem[imem_read_address[w]];
                    end else begin
                        imem_delay[w] <= imem_delay[w] - 1;
                    end
                end
            end
        end
    end

    // Data memory, each lane accepted after 0 to 3 cycles
    always @(posedge clk) begin
        for (int l = 0; l < num_lanes; l++) begin
            if (reset) begin
                dmem_write_ready[l] <= 1'b0;
                dmem_pending[l] <= 1'b0;
                dmem_delay[l] <= {$random(seed)} % 4;
            end else begin
                if (dmem_pending[l]) begin
                    assert (dmem_write_valid[l]) else begin
                        errors++;
                        $display("At %0t dmem_write_valid[%0d] dropped before ready", $time, l);
                    end
                    expect_value($sformatf("dmem_write_address[%0d]", l),
                                 32'(dmem_write_address[l]), 32'(dmem_held_address[l]));
                    expect_value($sformatf("dmem_write_data[%0d]", l),
                                 32'(dmem_write_data[l]), 32'(dmem_held_data[l]));
                end
                dmem_pending[l] <= dmem_write_valid[l] && !dmem_write_ready[l];
                dmem_held_address[l] <= dmem_write_address[l];
                dmem_held_data[l] <= dmem_write_data[l];
                if (dmem_write_valid[l] && dmem_write_ready[l]) begin
                    match_write(lane_id_t'(l), dmem_write_address[l], dmem_write_data[l]);
                    dmem_write_ready[l] <= 1'b0;
                    dmem_delay[l] <= {$random(seed)} % 4;
                end else if (dmem_write_valid[l]) begin
                    if (dmem_delay[l] == 0) begin
                        dmem_write_ready[l] <= 1'b1;
                    end else begin
                        dmem_delay[l] <= dmem_delay[l] - 1;
                    end
                end
            end
        end
    end

    task automatic run_test(input int t);
        int errors_before;
        int mode;
        int warps;
        int block;
        int base;
        int writes;
        string name;
        errors_before = errors;
        mode = t % 3;
        case (mode)
            0: name = "alu";
            1: name = "thread id";
            default: name = "mixed";
        endcase
        warps = (mode == 0) ? 1 : (mode == 1) ? 4 : 1 + {$random(seed)} % 4;
        block = (mode == 1) ? 1 + {$random(seed)} % 255 : {$random(seed)} % 256;
        base = {$random(seed)} % 256;
        gen_program(mode);
        build_expected(warps, data_t'(block));
        writes = expected.size();

        @(posedge clk);
        reset <= 1'b1;
        num_warps <= warp_count_t'(warps);
        block_id <= data_t'(block);
        base_pc <= pc_t'(base);
        load_program(pc_t'(base));
        // First edge still shows the previous run
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            if (k > 0) begin
                check_idle();
            end
        end
        reset <= 1'b0;
        repeat (3) begin
            @(posedge clk);
            check_idle();
        end
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;

        while (done !== 1'b1) begin
            @(posedge clk);
        end
        assert (expected.size() == 0) else begin
            errors++;
            $display("Done rose at %0t with %0d writes still missing", $time, expected.size());
        end
        // Second start must not restart the core
        for (int k = 0; k < 50; k++) begin
            @(posedge clk);
            if (k == 10) begin
                start <= 1'b1;
            end
            if (k == 11) begin
                start <= 1'b0;
            end
            expect_value("done", 32'(done), 1);
            expect_value("imem_read_valid", 32'(imem_read_valid), 0);
            expect_value("dmem_write_valid", 32'(dmem_write_valid), 0);
        end

        if (errors == errors_before) begin
            tests_passed++;
        end
        $display("Test %0d %s: %0d warps, block %0d, base %0d, %0d instructions, %0d writes, %s",
                 t, name, warps, block, base, program_words.size(), writes,
                 (errors == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 num_tests, tests_passed, num_tests - tests_passed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* compute_core.f */
+incdir+bench
verilog/core_pkg.sv
verilog/warp_fetcher.sv
verilog/warp_decoder.sv
verilog/warp_scheduler.sv
verilog/lane_alu.sv
verilog/lane_store_unit.sv
verilog/vector_reg_file.sv
verilog/compute_core.sv
bench/compute_core_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP = compute_core_tb
FILELIST = compute_core.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
